// ==== common/sd_host_defs.svh ====
`ifndef SD_HOST_DEFS_SVH
`define SD_HOST_DEFS_SVH

// --------------------------------------------------
// host controller register map offsets
// --------------------------------------------------
`define SD_REG_ADMA_ADDR        12'h058  // adma system address low word
`define SD_REG_BLK_COUNT        12'h006
`define SD_REG_ARGUMENT         12'h008
`define SD_REG_TF_MODE          12'h00C
`define SD_REG_COMMAND          12'h00E
`define SD_REG_RESPONSE         12'h010  // r1 card status lands here
`define SD_REG_INT_STAT         12'h030  // normal interrupt status

// command register fields
`define SD_CMD_WRITE_SINGLE     24
`define SD_CMD_WRITE_MULTI      25
`define SD_CMD_IDX_LSB          8
`define SD_CMD_IDX_W            6
`define SD_CMD_DATA_PRESENT_BIT 5
`define SD_CMD_RESP_48_BIT      1        // response type 48 bit

// status and mode bit positions
`define SD_TF_MODE_MULTI_BIT    5
`define SD_STAT_CMD_DONE_BIT    0
`define SD_STAT_TF_DONE_BIT     1
`define SD_RESP_READY_BIT       8        // ready for data in card status

`define SD_ADMA_DESCR_ADDR      1        // first descriptor line

// --------------------------------------------------
// widths and timer counts
// --------------------------------------------------
`define SD_REG_IDX_W            12
`define SD_REG_DATA_W           32
`define SD_REG_ATTR_W           3
`define SD_BLK_COUNT_W          16
`define SD_TF_MODE_W            16
`define SD_REG_GAP_CYCLES       4        // settle time after each access
`define SD_GAP_TIMER_W          3
`define SD_POLL_TIMER_W         26
`define SD_POLL_TIMEOUT_CYCLES  50000000 // 1 s at 50 MHz

`endif

// ==== common/sd_reg_pkg.sv ====
`include "sd_host_defs.svh"

// register map access between the sequencer and the host controller
package sd_reg_pkg;

	// --------------------------------------------------
	// plain field widths
	// --------------------------------------------------
	typedef logic [`SD_REG_IDX_W-1:0]  reg_index_t;  // byte offset in the map
	typedef logic [`SD_REG_DATA_W-1:0] reg_data_t;   // one register word
	typedef logic [`SD_REG_ATTR_W-1:0] reg_attr_t;   // how the write lands

	// write attributes understood by the register map
	typedef enum reg_attr_t {
		REG_ATTR_NORMAL = 3'd0,  // plain overwrite
		REG_ATTR_RW1C   = 3'd3   // ones clear, zeros keep
	} reg_attr_e;

	// one write request, strobe qualifies the other fields
	typedef struct packed {
		logic       strobe;
		reg_index_t index;
		reg_data_t  data;
		reg_attr_t  attr;
	} reg_wr_t;

endpackage

// ==== common/adma_xfer_pkg.sv ====
`include "sd_host_defs.svh"

// transfer setup and sequencer states
package adma_xfer_pkg;

	typedef logic [`SD_BLK_COUNT_W-1:0] blk_count_t;
	typedef logic [`SD_TF_MODE_W-1:0]   tf_mode_t;  // bit 5 selects multi block

	// held stable by the host for the whole transfer
	typedef struct packed {
		blk_count_t            blk_count;
		sd_reg_pkg::reg_data_t argument;   // card data address
		tf_mode_t              tf_mode;
	} xfer_req_t;

	// --------------------------------------------------
	// sequencer states
	// --------------------------------------------------
	typedef enum logic [4:0] {
		ST_IDLE,
		ST_WR_ADMA_ADDR,   // setup writes
		ST_WR_BLK_COUNT,
		ST_WR_ARGUMENT,
		ST_WR_TF_MODE,
		ST_WR_COMMAND,     // kicks off the sd command
		ST_GAP_WAIT,       // shared wait, leaves to ret_state
		ST_CMD_POLL_RD,
		ST_CMD_POLL,
		ST_CLR_CMD_DONE,
		ST_RESP_RD,
		ST_RESP_CHECK,
		ST_FIFO_START,
		ST_FIFO_WAIT,      // no timeout here
		ST_ADMA_START,
		ST_TF_POLL,
		ST_CLR_TF_DONE,
		ST_END
	} seq_state_e;

endpackage

// ==== bench/tb_data_tf_adma.sv ====
`include "sd_host_defs.svh"
`undef SD_POLL_TIMEOUT_CYCLES
`define SD_POLL_TIMEOUT_CYCLES 200  // short poll timeout for simulation

module tb_data_tf_adma;
	import sd_reg_pkg::*;
	import adma_xfer_pkg::*;

	localparam int NUM_TESTS  = 8;
	localparam int TEST_LIMIT = NUM_TESTS * (`SD_POLL_TIMEOUT_CYCLES * 2 + 400);  // cycles

	logic       clk             = 1'b0;
	logic       reset           = 1'b1;
	logic       start_xfer_strb = 1'b0;
	xfer_req_t  xfer_req        = '0;
	reg_data_t  rd_data         = '0;
	logic       fifo_rdy_strb   = 1'b0;
	reg_wr_t    reg_wr;
	reg_index_t rd_index;
	logic       wr_descr_table_strb;
	logic       strt_fifo_strb;
	logic       strt_adma_strb;
	logic       xfer_busy;

	// register model behavior for the running test
	logic        cmd_resp   = 1'b1;  // status bit 0 shows up
	logic        card_ready = 1'b1;  // response bit 8
	logic        tf_resp    = 1'b1;  // status bit 1 shows up
	reg_data_t   stat_reg   = '0;    // normal interrupt status
	int          cmd_cnt    = 0;
	int          tf_cnt     = 0;
	int          fifo_cnt   = 0;
	logic [31:0] lfsr       = 32'hf33a;
	int          test_num   = 0;
	int          run_errors = 0;
	int          error_count;
	int          check_count;
	int          seq_count;

	always #20 clk = ~clk;

	data_tf_adma data_tf_adma_i (
		.clk                 (clk),
		.reset               (reset),
		.start_xfer_strb     (start_xfer_strb),
		.xfer_req            (xfer_req),
		.rd_data             (rd_data),
		.fifo_rdy_strb       (fifo_rdy_strb),
		.reg_wr              (reg_wr),
		.rd_index            (rd_index),
		.wr_descr_table_strb (wr_descr_table_strb),
		.strt_fifo_strb      (strt_fifo_strb),
		.strt_adma_strb      (strt_adma_strb),
		.xfer_busy           (xfer_busy)
	);

	tb_checker tb_checker_i (
		.clk                 (clk),
		.reset               (reset),
		.start_xfer_strb     (start_xfer_strb),
		.xfer_req            (xfer_req),
		.reg_wr              (reg_wr),
		.rd_index            (rd_index),
		.wr_descr_table_strb (wr_descr_table_strb),
		.strt_fifo_strb      (strt_fifo_strb),
		.strt_adma_strb      (strt_adma_strb),
		.xfer_busy           (xfer_busy),
		.cmd_resp            (cmd_resp),
		.card_ready          (card_ready),
		.tf_resp             (tf_resp),
		.test_num            (test_num),
		.error_count         (error_count),
		.check_count         (check_count),
		.seq_count           (seq_count)
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);  // one step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// --------------------------------------------------
	// host controller register model
	// --------------------------------------------------
	always @(posedge clk) begin : reg_model
		reg_data_t stat_next;
		stat_next = stat_reg;
		if (cmd_cnt == 1 && cmd_resp)
			stat_next[`SD_STAT_CMD_DONE_BIT] = 1'b1;
		if (tf_cnt == 1 && tf_resp)
			stat_next[`SD_STAT_TF_DONE_BIT] = 1'b1;
		if (reg_wr.strobe && reg_wr.index == `SD_REG_INT_STAT && reg_wr.attr == REG_ATTR_RW1C)
			stat_next = stat_next & ~reg_wr.data;  // ones clear
		if (start_xfer_strb)
			stat_next = '0;  // fresh status per transfer
		stat_reg <= stat_next;

		if (reg_wr.strobe && reg_wr.index == `SD_REG_COMMAND)
			cmd_cnt <= 6;  // command done a few cycles on
		else if (cmd_cnt > 0)
			cmd_cnt <= cmd_cnt - 1;
		if (strt_adma_strb)
			tf_cnt <= 8;
		else if (tf_cnt > 0)
			tf_cnt <= tf_cnt - 1;
		if (strt_fifo_strb)
			fifo_cnt <= 10;
		else if (fifo_cnt > 0)
			fifo_cnt <= fifo_cnt - 1;
		fifo_rdy_strb <= (fifo_cnt == 1);  // 10 cycles after the fifo start

		case (rd_index)  // one cycle read latency
			`SD_REG_INT_STAT: rd_data <= stat_reg;
			`SD_REG_RESPONSE: rd_data <= card_ready ? 32'h0000_0900 : 32'h0000_0800;
			default:          rd_data <= '0;
		endcase
	end

	// runs one transfer and returns once busy has dropped
	task automatic run_test(input logic multi, input logic cmd_ok, input logic ready,
		input logic tf_ok);
		@(posedge clk);
		cmd_resp           <= cmd_ok;
		card_ready         <= ready;
		tf_resp            <= tf_ok;
		test_num           <= test_num + 1;
		xfer_req.blk_count <= blk_count_t'(random_bits(16));
		xfer_req.argument  <= random_bits(32);
		xfer_req.tf_mode   <= multi ? 16'h0023 : 16'h0001;  // dma on and bit 5 for multi
		start_xfer_strb    <= 1'b1;
		@(posedge clk);
		start_xfer_strb <= 1'b0;
		@(posedge clk);
		while (!xfer_busy)
			@(posedge clk);
		while (xfer_busy)
			@(posedge clk);
		repeat (6) @(posedge clk);  // idle between transfers
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		run_test(1'b0, 1'b1, 1'b1, 1'b1);  // single block
		run_test(1'b1, 1'b1, 1'b1, 1'b1);  // multi block
		run_test(1'b0, 1'b1, 1'b0, 1'b1);  // card not ready
		run_test(1'b1, 1'b0, 1'b1, 1'b1);  // command never completes
		run_test(1'b0, 1'b1, 1'b1, 1'b1);  // normal after that timeout
		run_test(1'b0, 1'b1, 1'b1, 1'b0);  // transfer never completes
		run_test(1'b1, 1'b1, 1'b1, 1'b1);
		run_test(1'b0, 1'b1, 1'b1, 1'b1);
		@(negedge clk);
		if (seq_count != NUM_TESTS) begin
			run_errors++;
			$display("only %0d of %0d transfers reached the end of busy", seq_count, NUM_TESTS);
		end
		$display("checks %0d, errors %0d", check_count, error_count + run_errors);
		if (error_count + run_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (TEST_LIMIT) @(posedge clk);
		$display("run did not end within %0d cycles, the DUT appears to hang", TEST_LIMIT);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== bench/tb_checker.sv ====
`include "sd_host_defs.svh"

// watches the DUT ports and compares register traffic with the expected list
module tb_checker (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start_xfer_strb,
	input  adma_xfer_pkg::xfer_req_t xfer_req,
	input  sd_reg_pkg::reg_wr_t      reg_wr,
	input  sd_reg_pkg::reg_index_t   rd_index,
	input  logic                     wr_descr_table_strb,
	input  logic                     strt_fifo_strb,
	input  logic                     strt_adma_strb,
	input  logic                     xfer_busy,
	input  logic                     cmd_resp,
	input  logic                     card_ready,
	input  logic                     tf_resp,
	input  int                       test_num,
	output int                       error_count,
	output int                       check_count,
	output int                       seq_count
);
	import sd_reg_pkg::*;
	import adma_xfer_pkg::*;

	typedef enum logic [1:0] {EV_NONE, EV_WRITE, EV_FIFO, EV_ADMA} ev_kind_e;

	// one observed or expected step
	typedef struct packed {
		ev_kind_e   kind;
		reg_index_t index;
		reg_data_t  data;
		reg_attr_t  attr;
	} ev_t;

	int   pos;         // steps seen in this transfer
	int   cycle;
	int   last_wr;     // cycle of the previous write strobe
	logic have_wr;
	logic start_seen;
	logic busy_d;

	function automatic ev_t wr_event(reg_index_t idx, reg_data_t data, reg_attr_t attr);
		ev_t ev;
		ev.kind  = EV_WRITE;
		ev.index = idx;
		ev.data  = data;
		ev.attr  = attr;
		return ev;
	endfunction

	function automatic ev_t pulse_event(ev_kind_e kind);
		ev_t ev;
		ev       = '0;
		ev.kind  = kind;
		return ev;
	endfunction

	// --------------------------------------------------
	// reference model giving step pos of one transfer
	// --------------------------------------------------
	function automatic ev_t expected_event(xfer_req_t req, logic cmd_ok, logic ready,
		logic tf_ok, int pos_in);
		ev_t list [9];
		int  len;
		list[0] = wr_event(`SD_REG_ADMA_ADDR, 32'd1, REG_ATTR_NORMAL);
		list[1] = wr_event(`SD_REG_BLK_COUNT, reg_data_t'(req.blk_count), REG_ATTR_NORMAL);
		list[2] = wr_event(`SD_REG_ARGUMENT, req.argument, REG_ATTR_NORMAL);
		list[3] = wr_event(`SD_REG_TF_MODE, reg_data_t'(req.tf_mode), REG_ATTR_NORMAL);
		list[4] = wr_event(`SD_REG_COMMAND, req.tf_mode[5] ? 32'h1922 : 32'h1822,
			REG_ATTR_NORMAL);  // cmd25 or cmd24
		list[5] = wr_event(`SD_REG_INT_STAT, 32'd1, REG_ATTR_RW1C);
		list[6] = pulse_event(EV_FIFO);
		list[7] = pulse_event(EV_ADMA);
		list[8] = wr_event(`SD_REG_INT_STAT, 32'd2, REG_ATTR_RW1C);
		if (!cmd_ok)
			len = 5;  // nothing after the command
		else if (!ready)
			len = 6;
		else if (!tf_ok)
			len = 8;  // no transfer done clear
		else
			len = 9;
		if (pos_in < len)
			return list[pos_in];
		return pulse_event(EV_NONE);
	endfunction

	// read index held while step pos_in shows up
	function automatic reg_index_t expected_rd_index(int pos_in);
		if (pos_in == 6)
			return `SD_REG_RESPONSE;  // response read before the fifo start
		return `SD_REG_INT_STAT;      // command or transfer complete poll
	endfunction

	function automatic string event_text(ev_t ev);
		case (ev.kind)
			EV_WRITE: return $sformatf("write %03h=%08h attr %0d", ev.index, ev.data, ev.attr);
			EV_FIFO:  return "fifo start";
			EV_ADMA:  return "adma start";
			default:  return "no event";
		endcase
	endfunction

	function automatic string test_name(int num, logic multi);
		string kind;
		if (!cmd_resp)
			kind = "cmd_timeout";
		else if (!card_ready)
			kind = "card_not_ready";
		else if (!tf_resp)
			kind = "tf_timeout";
		else if (multi)
			kind = "multi_block";
		else
			kind = "single_block";
		return $sformatf("test %0d %s", num, kind);
	endfunction

	always @(posedge clk) begin : compare
		ev_t        seen;
		ev_t        exp;
		reg_index_t exp_idx;
		string      name;
		cycle++;
		name = test_name(test_num, xfer_req.tf_mode[`SD_TF_MODE_MULTI_BIT]);
		if (reset) begin
			pos        = 0;
			have_wr    = 1'b0;
			start_seen = 1'b0;
			busy_d     = 1'b0;
		end else begin
			if (start_seen) begin  // start accepted one cycle ago
				check_count++;
				if (!(wr_descr_table_strb && xfer_busy)) begin
					error_count++;
					$display("%s: start got no descriptor strobe and busy", name);
				end
			end
			start_seen = start_xfer_strb && !xfer_busy;
			if (wr_descr_table_strb)
				pos = 0;

			seen = pulse_event(EV_NONE);
			if (reg_wr.strobe)
				seen = wr_event(reg_wr.index, reg_wr.data, reg_wr.attr);
			else if (strt_fifo_strb)
				seen = pulse_event(EV_FIFO);
			else if (strt_adma_strb)
				seen = pulse_event(EV_ADMA);
			if (seen.kind != EV_NONE) begin
				exp = expected_event(xfer_req, cmd_resp, card_ready, tf_resp, pos);
				check_count++;
				if (seen != exp) begin
					error_count++;
					$display("FAILED %s: expected %s, actual %s", name, event_text(exp),
						event_text(seen));
				end
				// steps after the command come from a poll or a read
				if (pos >= 5 && pos <= 8) begin
					exp_idx = expected_rd_index(pos);
					check_count++;
					if (rd_index != exp_idx) begin
						error_count++;
						$display("FAILED %s: expected rd_index %03h, actual %03h", name,
							exp_idx, rd_index);
					end
				end
				pos++;
			end

			// write spacing across all transfers
			if (reg_wr.strobe) begin
				check_count++;
				if (have_wr && (cycle - last_wr) < `SD_REG_GAP_CYCLES) begin
					error_count++;
					$display("%s: register writes only %0d cycles apart", name, cycle - last_wr);
				end
				have_wr = 1'b1;
				last_wr = cycle;
			end

			if (busy_d && !xfer_busy) begin  // transfer over
				seq_count++;
				check_count++;
				exp = expected_event(xfer_req, cmd_resp, card_ready, tf_resp, pos);
				if (exp.kind != EV_NONE) begin
					error_count++;
					$display("%s: busy fell while %s was still due", name, event_text(exp));
				end
			end
			busy_d = xfer_busy;
		end
	end

endmodule

// ==== hw/event_timer.sv ====
// one-shot delay, done fires COUNT cycles after the last start
module event_timer #(
	parameter int WIDTH = 8,
	parameter int COUNT = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic start_strb,
	output logic done
);

	logic [WIDTH-1:0] cnt;    // cycles left
	logic             armed;

	// armed from start until done
	always_ff @(posedge clk) begin
		if (reset)
			armed <= 1'b0;
		else if (start_strb)
			armed <= 1'b1;  // restart wins over done
		else if (done)
			armed <= 1'b0;
	end

	// counter only matters while armed
	always_ff @(posedge clk) begin
		if (start_strb)
			cnt <= WIDTH'(COUNT - 1);
		else if (armed && (cnt != '0))
			cnt <= cnt - 1'b1;
	end

	assign done = armed && (cnt == '0);

endmodule

// ==== hw/adma_seq/status_capture.sv ====
`include "sd_host_defs.svh"

// turns the register read-back word into the flags the sequencer polls
module status_capture (
	input  logic                  clk,
	input  logic                  reset,
	input  sd_reg_pkg::reg_data_t rd_data,
	input  logic                  tf_poll,
	output logic                  cmd_done,
	output logic                  card_ready,
	output logic                  tf_done
);

	logic tf_stat;    // bit 1 seen during the transfer poll
	logic tf_stat_d;  // one cycle late, for the edge

	// --------------------------------------------------
	// level flags, one register stage behind rd_data
	// --------------------------------------------------
	// only meaningful while the matching index is on rd_index
	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_done   <= 1'b0;
			card_ready <= 1'b0;
		end else begin
			cmd_done   <= rd_data[`SD_STAT_CMD_DONE_BIT];  // int stat bit 0
			card_ready <= rd_data[`SD_RESP_READY_BIT];     // r1 ready for data
		end
	end

	// --------------------------------------------------
	// transfer complete
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			tf_stat   <= 1'b0;
			tf_stat_d <= 1'b0;
			tf_done   <= 1'b0;
		end else begin
			tf_stat   <= tf_poll & rd_data[`SD_STAT_TF_DONE_BIT];  // zero outside the poll
			tf_stat_d <= tf_stat;
			tf_done   <= tf_stat & ~tf_stat_d;  // single pulse on the rise
		end
	end

endmodule

// ==== hw/adma_seq/adma_seq_fsm.sv ====
`include "sd_host_defs.svh"

// steps the host controller through one adma write transfer
module adma_seq_fsm (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start_xfer_strb,
	input  adma_xfer_pkg::xfer_req_t xfer_req,
	input  logic                    fifo_rdy_strb,
	input  logic                    gap_done,
	input  logic                    poll_timeout,
	input  logic                    cmd_done,
	input  logic                    card_ready,
	input  logic                    tf_done,
	output sd_reg_pkg::reg_wr_t     reg_wr,
	output sd_reg_pkg::reg_index_t  rd_index,
	output logic                    rd_strb,
	output logic                    tf_poll,
	output logic                    wr_descr_table_strb,
	output logic                    strt_fifo_strb,
	output logic                    strt_adma_strb,
	output logic                    xfer_busy
);
	import sd_reg_pkg::*;
	import adma_xfer_pkg::*;

	seq_state_e                state;
	seq_state_e                ret_state;  // where the gap wait goes next
	logic [`SD_CMD_IDX_W-1:0]  cmd_idx;
	reg_data_t                 cmd_word;

	// build one strobed write request
	function automatic reg_wr_t wr_req(reg_index_t idx, reg_data_t data, reg_attr_t attr);
		reg_wr_t req;
		req.strobe = 1'b1;
		req.index  = idx;
		req.data   = data;
		req.attr   = attr;
		return req;
	endfunction

	// --------------------------------------------------
	// command word, cmd24 or cmd25 with data and r1
	// --------------------------------------------------
	always_comb begin
		if (xfer_req.tf_mode[`SD_TF_MODE_MULTI_BIT])
			cmd_idx = `SD_CMD_IDX_W'(`SD_CMD_WRITE_MULTI);
		else
			cmd_idx = `SD_CMD_IDX_W'(`SD_CMD_WRITE_SINGLE);
		cmd_word = '0;
		cmd_word[`SD_CMD_IDX_LSB +: `SD_CMD_IDX_W] = cmd_idx;
		cmd_word[`SD_CMD_DATA_PRESENT_BIT] = 1'b1;
		cmd_word[`SD_CMD_RESP_48_BIT] = 1'b1;
	end

	assign tf_poll = (state == ST_TF_POLL);  // status_capture samples bit 1 only here

	// --------------------------------------------------
	// sequencer
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state               <= ST_IDLE;
			ret_state           <= ST_IDLE;
			reg_wr.strobe       <= 1'b0;  // fields keep whatever they had
			rd_index            <= '0;
			rd_strb             <= 1'b0;
			wr_descr_table_strb <= 1'b0;
			strt_fifo_strb      <= 1'b0;
			strt_adma_strb      <= 1'b0;
			xfer_busy           <= 1'b0;
		end else begin
			// strobes last one cycle
			reg_wr.strobe       <= 1'b0;
			rd_strb             <= 1'b0;
			wr_descr_table_strb <= 1'b0;
			strt_fifo_strb      <= 1'b0;
			strt_adma_strb      <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (start_xfer_strb) begin
						wr_descr_table_strb <= 1'b1;  // descriptor table build
						xfer_busy           <= 1'b1;
						state               <= ST_WR_ADMA_ADDR;
					end
				end
				ST_WR_ADMA_ADDR: begin
					reg_wr    <= wr_req(`SD_REG_ADMA_ADDR, `SD_ADMA_DESCR_ADDR, REG_ATTR_NORMAL);
					ret_state <= ST_WR_BLK_COUNT;
					state     <= ST_GAP_WAIT;
				end
				ST_WR_BLK_COUNT: begin
					reg_wr    <= wr_req(`SD_REG_BLK_COUNT, reg_data_t'(xfer_req.blk_count),
						REG_ATTR_NORMAL);
					ret_state <= ST_WR_ARGUMENT;
					state     <= ST_GAP_WAIT;
				end
				ST_WR_ARGUMENT: begin
					reg_wr    <= wr_req(`SD_REG_ARGUMENT, xfer_req.argument, REG_ATTR_NORMAL);
					ret_state <= ST_WR_TF_MODE;
					state     <= ST_GAP_WAIT;
				end
				ST_WR_TF_MODE: begin
					reg_wr    <= wr_req(`SD_REG_TF_MODE, reg_data_t'(xfer_req.tf_mode),
						REG_ATTR_NORMAL);
					ret_state <= ST_WR_COMMAND;
					state     <= ST_GAP_WAIT;
				end
				ST_WR_COMMAND: begin
					reg_wr    <= wr_req(`SD_REG_COMMAND, cmd_word, REG_ATTR_NORMAL);
					ret_state <= ST_CMD_POLL_RD;
					state     <= ST_GAP_WAIT;
				end
				ST_GAP_WAIT: begin
					if (gap_done)
						state <= ret_state;
				end

				// command complete
				ST_CMD_POLL_RD: begin
					rd_index  <= `SD_REG_INT_STAT;  // held through the poll
					rd_strb   <= 1'b1;              // also restarts the timeout
					ret_state <= ST_CMD_POLL;
					state     <= ST_GAP_WAIT;       // let rd_data settle first
				end
				ST_CMD_POLL: begin
					if (cmd_done)
						state <= ST_CLR_CMD_DONE;
					else if (poll_timeout)
						state <= ST_END;  // no response from the card
				end
				ST_CLR_CMD_DONE: begin
					reg_wr    <= wr_req(`SD_REG_INT_STAT, reg_data_t'(1) << `SD_STAT_CMD_DONE_BIT,
						REG_ATTR_RW1C);
					ret_state <= ST_RESP_RD;
					state     <= ST_GAP_WAIT;
				end
				ST_RESP_RD: begin
					rd_index  <= `SD_REG_RESPONSE;
					rd_strb   <= 1'b1;
					ret_state <= ST_RESP_CHECK;
					state     <= ST_GAP_WAIT;
				end
				ST_RESP_CHECK: begin
					if (card_ready) begin
						state <= ST_FIFO_START;
					end else begin
						xfer_busy <= 1'b0;  // card busy, give up quietly
						state     <= ST_IDLE;
					end
				end

				// data phase
				ST_FIFO_START: begin
					strt_fifo_strb <= 1'b1;  // fill the tx fifo first
					state          <= ST_FIFO_WAIT;
				end
				ST_FIFO_WAIT: begin
					if (fifo_rdy_strb)
						state <= ST_ADMA_START;
				end
				ST_ADMA_START: begin
					strt_adma_strb <= 1'b1;
					rd_index       <= `SD_REG_INT_STAT;
					rd_strb        <= 1'b1;
					ret_state      <= ST_TF_POLL;
					state          <= ST_GAP_WAIT;
				end
				ST_TF_POLL: begin
					if (tf_done)
						state <= ST_CLR_TF_DONE;
					else if (poll_timeout)
						state <= ST_END;
				end
				ST_CLR_TF_DONE: begin
					reg_wr    <= wr_req(`SD_REG_INT_STAT, reg_data_t'(1) << `SD_STAT_TF_DONE_BIT,
						REG_ATTR_RW1C);
					ret_state <= ST_END;
					state     <= ST_GAP_WAIT;
				end
				ST_END: begin
					xfer_busy <= 1'b0;
					state     <= ST_IDLE;
				end
				default: begin
					xfer_busy <= 1'b0;  // unused code, recover
					state     <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== hw/data_tf_adma.sv ====
`include "sd_host_defs.svh"

// adma write transfer sequencer, top level
module data_tf_adma (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start_xfer_strb,
	input  adma_xfer_pkg::xfer_req_t xfer_req,
	input  sd_reg_pkg::reg_data_t    rd_data,
	input  logic                     fifo_rdy_strb,
	output sd_reg_pkg::reg_wr_t      reg_wr,
	output sd_reg_pkg::reg_index_t   rd_index,
	output logic                     wr_descr_table_strb,
	output logic                     strt_fifo_strb,
	output logic                     strt_adma_strb,
	output logic                     xfer_busy
);

	logic rd_strb;       // a poll or read begins
	logic tf_poll;
	logic cmd_done;
	logic card_ready;
	logic tf_done;
	logic gap_done;      // settle time after any access is over
	logic poll_timeout;

	adma_seq_fsm adma_seq_fsm_i (
		.clk                 (clk),
		.reset               (reset),
		.start_xfer_strb     (start_xfer_strb),
		.xfer_req            (xfer_req),
		.fifo_rdy_strb       (fifo_rdy_strb),
		.gap_done            (gap_done),
		.poll_timeout        (poll_timeout),
		.cmd_done            (cmd_done),
		.card_ready          (card_ready),
		.tf_done             (tf_done),
		.reg_wr              (reg_wr),
		.rd_index            (rd_index),
		.rd_strb             (rd_strb),
		.tf_poll             (tf_poll),
		.wr_descr_table_strb (wr_descr_table_strb),
		.strt_fifo_strb      (strt_fifo_strb),
		.strt_adma_strb      (strt_adma_strb),
		.xfer_busy           (xfer_busy)
	);

	status_capture status_capture_i (
		.clk        (clk),
		.reset      (reset),
		.rd_data    (rd_data),
		.tf_poll    (tf_poll),
		.cmd_done   (cmd_done),
		.card_ready (card_ready),
		.tf_done    (tf_done)
	);

	// --------------------------------------------------
	// timers
	// --------------------------------------------------
	event_timer #(
		.WIDTH (`SD_GAP_TIMER_W),
		.COUNT (`SD_REG_GAP_CYCLES)
	) gap_timer_i (
		.clk        (clk),
		.reset      (reset),
		.start_strb (rd_strb | reg_wr.strobe),  // every register access
		.done       (gap_done)
	);

	event_timer #(
		.WIDTH (`SD_POLL_TIMER_W),
		.COUNT (`SD_POLL_TIMEOUT_CYCLES)
	) timeout_timer_i (
		.clk        (clk),
		.reset      (reset),
		.start_strb (rd_strb),
		.done       (poll_timeout)
	);

endmodule

// ==== project.f ====
+incdir+common
common/sd_reg_pkg.sv
common/adma_xfer_pkg.sv
bench/tb_data_tf_adma.sv
bench/tb_checker.sv
hw/event_timer.sv
hw/adma_seq/status_capture.sv
hw/adma_seq/adma_seq_fsm.sv
hw/data_tf_adma.sv

// ==== Bender.yml ====
package:
  name: data_tf_adma

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sd_reg_pkg.sv
      - common/adma_xfer_pkg.sv
      - bench/tb_data_tf_adma.sv
      - bench/tb_checker.sv
      - hw/event_timer.sv
      - hw/adma_seq/status_capture.sv
      - hw/adma_seq/adma_seq_fsm.sv
      - hw/data_tf_adma.sv
